//--- rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  wb_sel_t;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_ARI_I  = 7'b0010011;
    localparam logic [6:0] OPC_ARI_R  = 7'b0110011;
    localparam logic [6:0] OPC_CSR    = 7'b1110011;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Writeback sources
    localparam wb_sel_t WB_PC4 = 2'd0;
    localparam wb_sel_t WB_ALU = 2'd1;
    localparam wb_sel_t WB_MEM = 2'd2;

    // Instruction field positions
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int CSR_LSB = 20;
    localparam int ALT_BIT = 30;

    // ADDI x0, x0, 0
    localparam word_t INSTR_NOP = 32'h0000_0013;

    localparam logic [11:0] CSR_TOHOST = 12'h51E;

endpackage

//--- rv_ifc.sv
`timescale 1ns/1ps

interface id_x_if;
    logic              valid;
    rv_pkg::word_t     pc;
    rv_pkg::word_t     rs1_val;
    rv_pkg::word_t     rs2_val;
    rv_pkg::word_t     imm;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::alu_op_t   alu_op;
    logic              a_sel_pc;
    logic              b_sel_imm;
    logic              is_branch;
    logic [2:0]        funct3;
    logic              mem_write;
    logic              reg_write;
    rv_pkg::wb_sel_t   wb_sel;
    logic              csr_write;
    logic              csr_uimm_sel;
    // Taken branch redirect back towards fetch
    logic              redirect;
    rv_pkg::word_t     redirect_pc;

    modport decode (
        output valid, pc, rs1_val, rs2_val, imm, rd, rs1, rs2, alu_op, a_sel_pc, b_sel_imm,
               is_branch, funct3, mem_write, reg_write, wb_sel, csr_write, csr_uimm_sel,
        input  redirect, redirect_pc
    );

    modport execute (
        input  valid, pc, rs1_val, rs2_val, imm, rd, rs1, rs2, alu_op, a_sel_pc, b_sel_imm,
               is_branch, funct3, mem_write, reg_write, wb_sel, csr_write, csr_uimm_sel,
        output redirect, redirect_pc
    );
endinterface

interface dmem_if;
    rv_pkg::word_t addr;
    rv_pkg::word_t wdata;
    rv_pkg::word_t rdata;
    logic          we;

    modport master (output addr, wdata, we, input rdata);
    modport slave (input addr, wdata, we, output rdata);
endinterface

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int            IMEM_AWIDTH = 10,
    parameter rv_pkg::word_t RESET_PC    = '0
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   imem_load_en,
    input  logic [IMEM_AWIDTH-1:0] imem_load_addr,
    input  rv_pkg::word_t          imem_load_data,
    id_x_if.decode                 id_x,
    output rv_pkg::word_t          instr,
    input  rv_pkg::word_t          imm,
    input  rv_pkg::reg_addr_t      rd,
    input  rv_pkg::reg_addr_t      rs1,
    input  rv_pkg::reg_addr_t      rs2,
    input  rv_pkg::alu_op_t        alu_op,
    input  logic                   a_sel_pc,
    input  logic                   b_sel_imm,
    input  logic                   is_branch,
    input  logic [2:0]             funct3,
    input  logic                   mem_write,
    input  logic                   reg_write,
    input  rv_pkg::wb_sel_t        wb_sel,
    input  logic                   csr_write,
    input  logic                   csr_uimm_sel,
    output rv_pkg::reg_addr_t      ra1,
    output rv_pkg::reg_addr_t      ra2,
    input  rv_pkg::word_t          rd1,
    input  rv_pkg::word_t          rd2
);

    rv_pkg::word_t imem [2**IMEM_AWIDTH];
    rv_pkg::word_t pc_q;
    rv_pkg::word_t pc_id_q;
    rv_pkg::word_t imem_q;
    rv_pkg::word_t pc_next;
    logic          kill_q;
    logic          kill;
    logic          jal_taken;

    // Load port and synchronous fetch read
    always_ff @(posedge clk) begin
        if (imem_load_en) begin
            imem[imem_load_addr] <= imem_load_data;
        end
        imem_q  <= imem[pc_q[IMEM_AWIDTH+1:2]];
        pc_id_q <= pc_q;
    end

    // A taken branch also squashes the instruction sitting in decode
    assign kill      = kill_q || id_x.redirect;
    assign instr     = kill ? rv_pkg::INSTR_NOP : imem_q;
    assign jal_taken = (instr[6:0] == rv_pkg::OPC_JAL);

    always_comb begin
        if (id_x.redirect) begin
            pc_next = id_x.redirect_pc;
        end else if (jal_taken) begin
            pc_next = pc_id_q + imm;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    // First decode slot after reset holds a stale memory word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q   <= RESET_PC;
            kill_q <= 1'b1;
        end else begin
            pc_q   <= pc_next;
            kill_q <= id_x.redirect || jal_taken;
        end
    end

    assign ra1 = rs1;
    assign ra2 = rs2;

    // Decoded bundle towards execute
    assign id_x.valid        = !kill;
    assign id_x.pc           = pc_id_q;
    assign id_x.rs1_val      = rd1;
    assign id_x.rs2_val      = rd2;
    assign id_x.imm          = imm;
    assign id_x.rd           = rd;
    assign id_x.rs1          = rs1;
    assign id_x.rs2          = rs2;
    assign id_x.alu_op       = alu_op;
    assign id_x.a_sel_pc     = a_sel_pc;
    assign id_x.b_sel_imm    = b_sel_imm;
    assign id_x.is_branch    = is_branch;
    assign id_x.funct3       = funct3;
    assign id_x.mem_write    = mem_write;
    assign id_x.reg_write    = reg_write;
    assign id_x.wb_sel       = wb_sel;
    assign id_x.csr_write    = csr_write;
    assign id_x.csr_uimm_sel = csr_uimm_sel;

    pc_aligned_a: assert property (@(posedge clk) disable iff (!arst_n) pc_q[1:0] == 2'b00);

endmodule

//--- control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::word_t     imm,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::alu_op_t   alu_op,
    output logic              a_sel_pc,
    output logic              b_sel_imm,
    output logic              is_branch,
    output logic [2:0]        funct3,
    output logic              mem_write,
    output logic              reg_write,
    output rv_pkg::wb_sel_t   wb_sel,
    output logic              csr_write,
    output logic              csr_uimm_sel
);

    logic [6:0]      opcode;
    logic            alt;
    rv_pkg::alu_op_t alu_f;

    assign opcode = instr[6:0];
    assign alt    = instr[rv_pkg::ALT_BIT];
    assign rd     = instr[rv_pkg::RD_LSB +: 5];
    assign rs1    = instr[rv_pkg::RS1_LSB +: 5];
    assign rs2    = instr[rv_pkg::RS2_LSB +: 5];
    assign funct3 = instr[rv_pkg::F3_LSB +: 3];

    // Unknown opcodes fall out of every list below, so they act as a NOP
    assign reg_write = opcode inside {rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_JAL,
                                      rv_pkg::OPC_LOAD, rv_pkg::OPC_ARI_I, rv_pkg::OPC_ARI_R};
    assign b_sel_imm = opcode inside {rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_BRANCH,
                                      rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_ARI_I};
    assign a_sel_pc  = opcode inside {rv_pkg::OPC_AUIPC, rv_pkg::OPC_BRANCH};
    assign is_branch = (opcode == rv_pkg::OPC_BRANCH);
    assign mem_write = (opcode == rv_pkg::OPC_STORE);
    assign wb_sel    = (opcode == rv_pkg::OPC_JAL)  ? rv_pkg::WB_PC4 :
                       (opcode == rv_pkg::OPC_LOAD) ? rv_pkg::WB_MEM : rv_pkg::WB_ALU;

    // Only CSRRW and CSRRWI to tohost
    assign csr_write    = (opcode == rv_pkg::OPC_CSR) && (funct3[1:0] == 2'b01) &&
                          (instr[rv_pkg::CSR_LSB +: 12] == rv_pkg::CSR_TOHOST);
    assign csr_uimm_sel = funct3[2];

    always_comb begin
        case (funct3)
            3'b000:  alu_f = (alt && opcode == rv_pkg::OPC_ARI_R) ? rv_pkg::ALU_SUB
                                                                 : rv_pkg::ALU_ADD;
            3'b001:  alu_f = rv_pkg::ALU_SLL;
            3'b010:  alu_f = rv_pkg::ALU_SLT;
            3'b011:  alu_f = rv_pkg::ALU_SLTU;
            3'b100:  alu_f = rv_pkg::ALU_XOR;
            3'b101:  alu_f = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  alu_f = rv_pkg::ALU_OR;
            default: alu_f = rv_pkg::ALU_AND;
        endcase
    end

    assign alu_op = (opcode == rv_pkg::OPC_LUI) ? rv_pkg::ALU_PASS_B :
                    (opcode inside {rv_pkg::OPC_ARI_I, rv_pkg::OPC_ARI_R}) ? alu_f :
                    rv_pkg::ALU_ADD;

    // Immediate formats with the sign taken from bit 31
    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:
                imm = {instr[31:12], 12'b0};
            rv_pkg::OPC_JAL:
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            rv_pkg::OPC_BRANCH:
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::OPC_STORE:
                imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
            rv_pkg::OPC_LOAD, rv_pkg::OPC_ARI_I:
                imm = {{21{instr[31]}}, instr[30:20]};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    input  rv_pkg::reg_addr_t wa,
    input  logic              we,
    input  rv_pkg::word_t     wd
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // x0 pinned to zero, then write-through of the value being written
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

    no_x0_write_a: assert property (@(posedge clk) disable iff (!arst_n) !(we && wa == '0));

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              arst_n,
    id_x_if.execute           id_x,
    dmem_if.master            dmem,
    input  rv_pkg::word_t     fwd_data,
    input  rv_pkg::reg_addr_t fwd_rd,
    input  logic              fwd_we,
    output logic              wb_valid,
    output rv_pkg::word_t     wb_pc,
    output rv_pkg::word_t     wb_alu,
    output rv_pkg::reg_addr_t wb_rd,
    output logic              wb_reg_write,
    output rv_pkg::wb_sel_t   wb_sel,
    output logic              wb_csr_write,
    output rv_pkg::word_t     wb_csr_data
);

    logic              valid_q, is_branch_q, mem_write_q, reg_write_q, csr_write_q;
    logic              a_sel_pc_q, b_sel_imm_q, csr_uimm_sel_q;
    logic [2:0]        funct3_q;
    rv_pkg::word_t     pc_q, rs1_val_q, rs2_val_q, imm_q;
    rv_pkg::reg_addr_t rd_q, rs1_q, rs2_q;
    rv_pkg::alu_op_t   alu_op_q;
    rv_pkg::wb_sel_t   wb_sel_q;
    rv_pkg::word_t     op_a, op_b, alu_a, alu_b, alu_res;
    logic              br_cond;

    ////////////////////////////////////////
    // ID/X register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q     <= 1'b0;
            is_branch_q <= 1'b0;
            mem_write_q <= 1'b0;
            reg_write_q <= 1'b0;
            csr_write_q <= 1'b0;
        end else begin
            valid_q     <= id_x.valid;
            is_branch_q <= id_x.is_branch;
            mem_write_q <= id_x.mem_write;
            reg_write_q <= id_x.reg_write;
            csr_write_q <= id_x.csr_write;
        end
    end

    always_ff @(posedge clk) begin
        pc_q           <= id_x.pc;
        rs1_val_q      <= id_x.rs1_val;
        rs2_val_q      <= id_x.rs2_val;
        imm_q          <= id_x.imm;
        rd_q           <= id_x.rd;
        rs1_q          <= id_x.rs1;
        rs2_q          <= id_x.rs2;
        alu_op_q       <= id_x.alu_op;
        a_sel_pc_q     <= id_x.a_sel_pc;
        b_sel_imm_q    <= id_x.b_sel_imm;
        funct3_q       <= id_x.funct3;
        wb_sel_q       <= id_x.wb_sel;
        csr_uimm_sel_q <= id_x.csr_uimm_sel;
    end

    // Forward from writeback whose fwd_we is never set for x0
    assign op_a  = (fwd_we && fwd_rd == rs1_q) ? fwd_data : rs1_val_q;
    assign op_b  = (fwd_we && fwd_rd == rs2_q) ? fwd_data : rs2_val_q;
    assign alu_a = a_sel_pc_q ? pc_q : op_a;
    assign alu_b = b_sel_imm_q ? imm_q : op_b;

    always_comb begin
        case (alu_op_q)
            rv_pkg::ALU_ADD:    alu_res = alu_a + alu_b;
            rv_pkg::ALU_SUB:    alu_res = alu_a - alu_b;
            rv_pkg::ALU_SLL:    alu_res = alu_a << alu_b[4:0];
            rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::ALU_SLTU:   alu_res = {31'b0, alu_a < alu_b};
            rv_pkg::ALU_XOR:    alu_res = alu_a ^ alu_b;
            rv_pkg::ALU_SRL:    alu_res = alu_a >> alu_b[4:0];
            rv_pkg::ALU_SRA:    alu_res = $signed(alu_a) >>> alu_b[4:0];
            rv_pkg::ALU_OR:     alu_res = alu_a | alu_b;
            rv_pkg::ALU_AND:    alu_res = alu_a & alu_b;
            rv_pkg::ALU_PASS_B: alu_res = alu_b;
            default:            alu_res = '0;
        endcase
    end

    // funct3[2:1] picks the compare, funct3[0] inverts it
    always_comb begin
        case (funct3_q[2:1])
            2'b00:   br_cond = (op_a == op_b);
            2'b10:   br_cond = $signed(op_a) < $signed(op_b);
            2'b11:   br_cond = op_a < op_b;
            default: br_cond = 1'b0;
        endcase
    end

    // Branch target comes out of the ALU as pc + imm
    assign id_x.redirect    = valid_q && is_branch_q && (br_cond ^ funct3_q[0]);
    assign id_x.redirect_pc = alu_res;

    assign dmem.addr  = alu_res;
    assign dmem.wdata = op_b;
    assign dmem.we    = valid_q && mem_write_q;

    ////////////////////////////////////////
    // X/WB register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_csr_write <= 1'b0;
        end else begin
            wb_valid     <= valid_q;
            wb_reg_write <= reg_write_q;
            wb_csr_write <= csr_write_q;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc       <= pc_q;
        wb_alu      <= alu_res;
        wb_rd       <= rd_q;
        wb_sel      <= wb_sel_q;
        wb_csr_data <= csr_uimm_sel_q ? {27'b0, rs1_q} : op_a;
    end

    // Both slots behind a taken branch come through squashed
    branch_kill_a: assert property (@(posedge clk) disable iff (!arst_n)
        id_x.redirect |-> valid_q ##1 !valid_q ##1 !valid_q);

endmodule

//--- data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_AWIDTH = 10
) (
    input  logic   clk,
    dmem_if.slave  bus
);

    rv_pkg::word_t          mem [2**DMEM_AWIDTH];
    logic [DMEM_AWIDTH-1:0] idx;

    // Word addressed with the byte offset dropped
    assign idx = bus.addr[DMEM_AWIDTH+1:2];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[idx] <= bus.wdata;
        end
        bus.rdata <= mem[idx];
    end

endmodule

//--- writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wb_valid,
    input  rv_pkg::word_t     wb_pc,
    input  rv_pkg::word_t     wb_alu,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              wb_reg_write,
    input  rv_pkg::wb_sel_t   wb_sel,
    input  logic              wb_csr_write,
    input  rv_pkg::word_t     wb_csr_data,
    input  rv_pkg::word_t     mem_rdata,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_wa,
    output rv_pkg::word_t     fwd_data,
    output rv_pkg::word_t     tohost,
    output logic              tohost_valid
);

    always_comb begin
        case (wb_sel)
            rv_pkg::WB_PC4: fwd_data = wb_pc + 32'd4;
            rv_pkg::WB_MEM: fwd_data = mem_rdata;
            default:        fwd_data = wb_alu;
        endcase
    end

    // Writes to x0 dropped here
    assign rf_we = wb_valid && wb_reg_write && (wb_rd != '0);
    assign rf_wa = wb_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tohost       <= '0;
            tohost_valid <= 1'b0;
        end else begin
            tohost_valid <= wb_valid && wb_csr_write;
            if (wb_valid && wb_csr_write) begin
                tohost <= wb_csr_data;
            end
        end
    end

endmodule

//--- rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
    parameter int            IMEM_AWIDTH = 10,
    parameter int            DMEM_AWIDTH = 10,
    parameter rv_pkg::word_t RESET_PC    = '0
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   imem_load_en,
    input  logic [IMEM_AWIDTH-1:0] imem_load_addr,
    input  rv_pkg::word_t          imem_load_data,
    output rv_pkg::word_t          tohost,
    output logic                   tohost_valid
);

    // ID-to-X bundle and data memory bus
    id_x_if id_x ();
    dmem_if dmem ();

    rv_pkg::word_t     instr, imm, rd1, rd2, fwd_data, wb_pc, wb_alu, wb_csr_data;
    rv_pkg::reg_addr_t rd, rs1, rs2, ra1, ra2, rf_wa, wb_rd;
    rv_pkg::alu_op_t   alu_op;
    rv_pkg::wb_sel_t   dec_wb_sel, wb_sel;
    logic [2:0]        funct3;
    logic              a_sel_pc, b_sel_imm, is_branch, mem_write, reg_write;
    logic              csr_write, csr_uimm_sel;
    logic              rf_we, wb_valid, wb_reg_write, wb_csr_write;

    fetch_stage #(.IMEM_AWIDTH(IMEM_AWIDTH), .RESET_PC(RESET_PC)) u_fetch (
        .clk, .arst_n, .imem_load_en, .imem_load_addr, .imem_load_data,
        .id_x(id_x.decode), .instr, .imm, .rd, .rs1, .rs2, .alu_op, .a_sel_pc,
        .b_sel_imm, .is_branch, .funct3, .mem_write, .reg_write, .wb_sel(dec_wb_sel),
        .csr_write, .csr_uimm_sel, .ra1, .ra2, .rd1, .rd2
    );

    control_decoder u_dec (
        .instr, .imm, .rd, .rs1, .rs2, .alu_op, .a_sel_pc, .b_sel_imm, .is_branch,
        .funct3, .mem_write, .reg_write, .wb_sel(dec_wb_sel), .csr_write, .csr_uimm_sel
    );

    reg_file u_rf (
        .clk, .arst_n, .ra1, .ra2, .rd1, .rd2, .wa(rf_wa), .we(rf_we), .wd(fwd_data)
    );

    execute_stage u_ex (
        .clk, .arst_n, .id_x(id_x.execute), .dmem(dmem.master), .fwd_data,
        .fwd_rd(rf_wa), .fwd_we(rf_we), .wb_valid, .wb_pc, .wb_alu, .wb_rd,
        .wb_reg_write, .wb_sel, .wb_csr_write, .wb_csr_data
    );

    data_mem #(.DMEM_AWIDTH(DMEM_AWIDTH)) u_dmem (
        .clk, .bus(dmem.slave)
    );

    writeback_stage u_wb (
        .clk, .arst_n, .wb_valid, .wb_pc, .wb_alu, .wb_rd, .wb_reg_write, .wb_sel,
        .wb_csr_write, .wb_csr_data, .mem_rdata(dmem.rdata), .rf_we, .rf_wa,
        .fwd_data, .tohost, .tohost_valid
    );

endmodule

//--- tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

////////////////////////////////////////
// RV32I instruction formats
////////////////////////////////////////
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

////////////////////////////////////////
// Program building blocks
////////////////////////////////////////
task automatic put(input logic [31:0] w);
    prog.push_back(w);
endtask

task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    put(i_type(imm, rs1, 3'b000, rd, 7'b0010011));
endtask

// CSRRW x0, tohost, rs
task automatic send(input logic [4:0] rs);
    put(i_type(12'h51E, rs, 3'b001, 5'd0, 7'b1110011));
endtask

// CSRRWI x0, tohost, uimm
task automatic send_uimm(input logic [4:0] uimm);
    put(i_type(12'h51E, uimm, 3'b101, 5'd0, 7'b1110011));
endtask

// LUI then ADDI with the upper part rounded for the sign of the low 12 bits
task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    put(u_type(hi[19:0], rd, 7'b0110111));
    addi(rd, rd, v[11:0]);
endtask

task automatic alu_send(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    put(r_type(f7, rs2, rs1, f3, rd));
    send(rd);
endtask

task automatic arith_prog(input logic [31:0] a, input logic [31:0] b,
                          input logic [11:0] imm);
    load_const(5'd1, a);
    load_const(5'd2, b);
    addi(5'd3, 5'd1, imm);
    send(5'd3);
    alu_send(7'h00, 3'b000, 5'd4, 5'd3, 5'd2);
    alu_send(7'h20, 3'b000, 5'd5, 5'd4, 5'd1);
    alu_send(7'h00, 3'b100, 5'd6, 5'd5, 5'd2);
    alu_send(7'h00, 3'b110, 5'd7, 5'd6, 5'd1);
    alu_send(7'h00, 3'b111, 5'd8, 5'd7, 5'd2);
    alu_send(7'h00, 3'b001, 5'd9, 5'd8, 5'd2);
    alu_send(7'h00, 3'b101, 5'd10, 5'd9, 5'd1);
    alu_send(7'h20, 3'b101, 5'd11, 5'd10, 5'd2);
    alu_send(7'h00, 3'b010, 5'd12, 5'd11, 5'd1);
    alu_send(7'h00, 3'b011, 5'd13, 5'd11, 5'd1);
endtask

// LUI at 0, AUIPC at 8
task automatic upper_prog(input logic [19:0] u1, input logic [19:0] u2);
    put(u_type(u1, 5'd1, 7'b0110111));
    send(5'd1);
    put(u_type(u2, 5'd2, 7'b0010111));
    send(5'd2);
endtask

task automatic mem_prog(input logic [31:0] d0, input logic [31:0] d1, input logic [31:0] d2);
    load_const(5'd1, d0);
    load_const(5'd2, d1);
    load_const(5'd3, d2);
    put(s_type(12'h010, 5'd1, 5'd0));
    put(s_type(12'h124, 5'd2, 5'd0));
    put(s_type(12'h7fc, 5'd3, 5'd0));
    put(i_type(12'h124, 5'd0, 3'b010, 5'd4, 7'b0000011));
    send(5'd4);
    put(i_type(12'h010, 5'd0, 3'b010, 5'd5, 7'b0000011));
    send(5'd5);
    put(i_type(12'h7fc, 5'd0, 3'b010, 5'd6, 7'b0000011));
    addi(5'd7, 5'd6, 12'd1);
    send(5'd7);
endtask

// x1 = -5, x2 = x3 = 7, x10 is the marker
task automatic branch_setup();
    addi(5'd1, 5'd0, 12'hffb);
    addi(5'd2, 5'd0, 12'd7);
    addi(5'd3, 5'd0, 12'd7);
    addi(5'd10, 5'd0, 12'd0);
endtask

// Taken target skips exactly the two slots that get killed
task automatic branch_case(input logic [2:0] f3, input logic [4:0] ra, input logic [4:0] rb);
    put(b_type(13'd12, rb, ra, f3));
    addi(5'd10, 5'd10, 12'd1);
    addi(5'd10, 5'd10, 12'd2);
    send(5'd10);
endtask

// JAL at 4 jumps over the word at 8
task automatic jump_prog();
    addi(5'd5, 5'd0, 12'd9);
    put(j_type(21'd8, 5'd1));
    addi(5'd5, 5'd0, 12'd77);
    send(5'd1);
    send(5'd5);
endtask

task automatic csr_prog(input logic [4:0] u);
    addi(5'd1, 5'd0, 12'd55);
    send_uimm(u);
    addi(5'd0, 5'd1, 12'd100);
    put(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
    send(5'd0);
    send_uimm(5'h1f);
endtask

`endif

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 2000;
    localparam int LOAD_CYCLES = 100;
    localparam int CLK_PERIOD  = 10;

    logic        clk;
    logic        arst_n;
    logic        imem_load_en;
    logic [9:0]  imem_load_addr;
    logic [31:0] imem_load_data;
    logic [31:0] tohost;
    logic        tohost_valid;

    logic [31:0] prog [$];
    logic [31:0] expect_q [$];
    int          errors;
    int          test_errors;
    int          failed;
    int          seed = 32'hb2a65420;

    `include "tb_programs.svh"

    rv_core_top UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .tohost         (tohost),
        .tohost_valid   (tohost_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Budget per test covers reset, load and the run itself
    initial begin
        #(NUM_TESTS * (TEST_CYCLES + LOAD_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Register contents set up by branch_setup
    function automatic logic [31:0] branch_reg(input logic [4:0] r);
        case (r)
            5'd1:       return 32'hffff_fffb;
            5'd2, 5'd3: return 32'd7;
            default:    return 32'd0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Load, reset and collect
    ////////////////////////////////////////
    task automatic run_program(input string name);
        int n;
        int cycles;
        int idx;
        put(j_type(21'd0, 5'd0));
        n = prog.size();
        test_errors = 0;
        for (int i = 0; i < ((n > 10) ? n : 10); i++) begin
            @(posedge clk);
            arst_n         <= 1'b0;
            imem_load_en   <= (i < n);
            imem_load_addr <= 10'(i);
            imem_load_data <= (i < n) ? prog[i] : 32'h0;
        end
        @(posedge clk);
        imem_load_en <= 1'b0;
        arst_n       <= 1'b1;
        // Collect tohost values mid-cycle
        cycles = 0;
        idx    = 0;
        while (expect_q.size() > 0 && cycles < TEST_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (tohost_valid) begin
                check($sformatf("tohost[%0d]", idx), tohost, expect_q.pop_front());
                idx++;
            end
        end
        if (expect_q.size() > 0) begin
            $display("Test %s timed out with %0d tohost values missing", name, expect_q.size());
            test_errors++;
        end
        if (test_errors != 0) begin
            failed++;
        end
        errors += test_errors;
        $display("Test %-8s %s, %0d error(s)", name, (test_errors == 0) ? "passed" : "failed",
                 test_errors);
        prog.delete();
        expect_q.delete();
    endtask

    task automatic alu_chain();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [11:0] imm;
        a   = $random(seed);
        b   = $random(seed);
        imm = $random(seed);
        arith_prog(a, b, imm);
        r = a + {{20{imm[11]}}, imm};
        expect_q.push_back(r);
        r = r + b;
        expect_q.push_back(r);
        r = r - a;
        expect_q.push_back(r);
        r = r ^ b;
        expect_q.push_back(r);
        r = r | a;
        expect_q.push_back(r);
        r = r & b;
        expect_q.push_back(r);
        r = r << b[4:0];
        expect_q.push_back(r);
        r = r >> a[4:0];
        expect_q.push_back(r);
        r = $signed(r) >>> b[4:0];
        expect_q.push_back(r);
        expect_q.push_back({31'b0, $signed(r) < $signed(a)});
        expect_q.push_back({31'b0, r < a});
        run_program("arith");
    endtask

    task automatic upper_imms();
        logic [19:0] u1;
        logic [19:0] u2;
        u1 = $random(seed);
        u2 = $random(seed);
        upper_prog(u1, u2);
        expect_q.push_back({u1, 12'b0});
        expect_q.push_back({u2, 12'b0} + 32'd8);
        run_program("upper");
    endtask

    task automatic mem_roundtrip();
        logic [31:0] d0;
        logic [31:0] d1;
        logic [31:0] d2;
        d0 = $random(seed);
        d1 = $random(seed);
        d2 = $random(seed);
        mem_prog(d0, d1, d2);
        expect_q.push_back(d1);
        expect_q.push_back(d0);
        expect_q.push_back(d2 + 32'd1);
        run_program("memory");
    endtask

    // Marker grows by 3 only when the branch falls through
    task automatic add_branch(input logic [2:0] f3, input logic [4:0] ra, input logic [4:0] rb);
        logic [31:0] marker;
        marker = (expect_q.size() == 0) ? 32'd0 : expect_q[$];
        if (!branch_taken(f3, branch_reg(ra), branch_reg(rb))) begin
            marker = marker + 32'd3;
        end
        branch_case(f3, ra, rb);
        expect_q.push_back(marker);
    endtask

    task automatic cond_branches();
        branch_setup();
        add_branch(3'b000, 5'd2, 5'd3);
        add_branch(3'b000, 5'd1, 5'd2);
        add_branch(3'b001, 5'd1, 5'd2);
        add_branch(3'b001, 5'd2, 5'd3);
        add_branch(3'b100, 5'd1, 5'd2);
        add_branch(3'b100, 5'd2, 5'd1);
        add_branch(3'b101, 5'd2, 5'd1);
        add_branch(3'b101, 5'd1, 5'd2);
        add_branch(3'b110, 5'd2, 5'd1);
        add_branch(3'b110, 5'd1, 5'd2);
        add_branch(3'b111, 5'd1, 5'd2);
        add_branch(3'b111, 5'd2, 5'd1);
        run_program("branch");
    endtask

    task automatic jal_link();
        jump_prog();
        // Link is the JAL address plus 4
        expect_q.push_back(32'd4 + 32'd4);
        expect_q.push_back(32'd9);
        run_program("jump");
    endtask

    task automatic csr_tohost();
        logic [4:0] u;
        u = $random(seed);
        csr_prog(u);
        expect_q.push_back({27'b0, u});
        expect_q.push_back(32'd0);
        expect_q.push_back(32'd31);
        run_program("csr");
    endtask

    initial begin
        arst_n         = 1'b0;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        errors         = 0;
        failed         = 0;
        alu_chain();
        upper_imms();
        mem_roundtrip();
        cond_branches();
        jal_link();
        csr_tohost();
        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
rv_pkg.sv
rv_ifc.sv
fetch_stage.sv
control_decoder.sv
reg_file.sv
execute_stage.sv
data_mem.sv
writeback_stage.sv
rv_core_top.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rv_pkg.sv
      - rv_ifc.sv
      - fetch_stage.sv
      - control_decoder.sv
      - reg_file.sv
      - execute_stage.sv
      - data_mem.sv
      - writeback_stage.sv
      - rv_core_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
